/* verilog/eth_pkg.sv */
package eth_pkg;

  // --------------------------------------------------------------------------
  // widths that carry a meaning
  // --------------------------------------------------------------------------

  // host register bus
  typedef logic [15:0] host_addr_t;
  typedef logic [15:0] host_data_t;
  typedef logic [1:0]  host_sel_t;

  // counter and frame info
  typedef logic [63:0] stamp_t;
  typedef logic [11:0] frame_len_t;

  // receive slot memory
  typedef logic [31:0] slot_word_t;
  typedef logic [8:0]  slot_addr_t;
  typedef logic [3:0]  slot_be_t;
  typedef logic [3:0]  slot_status_t;

  typedef logic [7:0]  gmii_byte_t;

  typedef enum logic [2:0] {
    IDLE,
    PREAMBLE,
    DATA,
    DROP,
    DONE
  } rx_state_t;

  // --------------------------------------------------------------------------
  // constants
  // --------------------------------------------------------------------------

  localparam int SLOT_WORDS = 512;

  // region code in address bits 15:13
  localparam logic [2:0] REGION_GLOBAL = 3'd0;
  localparam logic [2:0] REGION_RX     = 3'd4;

  // 16-bit word indices inside a region
  localparam int GLB_STATUS_WORD  = 0;
  localparam int GLB_COUNTER_WORD = 2;
  localparam int RX_STAMP_WORD    = 0;
  localparam int RX_LEN_WORD      = 6;
  localparam int RX_DATA_WORD     = 8;

  // extra wait cycles on a low-half slot read
  localparam int RAM_READ_WAIT = 3;

  localparam gmii_byte_t   GMII_PREAMBLE = 8'h55;
  localparam gmii_byte_t   GMII_SFD      = 8'hD5;
  localparam slot_status_t STATUS_RESET  = 4'b0010;

endpackage

/* verilog/slot_ram.sv */
`timescale 1ns/1ps

module slot_ram import eth_pkg::*; (
  input  logic       clk_125,
  input  logic       core_rst_n,
  // port A, host side
  input  slot_addr_t a_addr_i,
  input  slot_word_t a_data_i,
  input  slot_be_t   a_be_i,
  input  logic       a_we_i,
  output slot_word_t a_q_o,
  // port B, receiver side, write only
  input  slot_addr_t b_addr_i,
  input  slot_word_t b_data_i,
  input  slot_be_t   b_be_i,
  input  logic       b_we_i
);

  slot_word_t mem [SLOT_WORDS];

  // byte lanes written independently on each port
  always_ff @(posedge clk_125) begin
    for (int i = 0; i < $bits(slot_be_t); i++) begin
      if (a_we_i && a_be_i[i]) begin
        mem[a_addr_i][i*8 +: 8] <= a_data_i[i*8 +: 8];
      end
      if (b_we_i && b_be_i[i]) begin
        mem[b_addr_i][i*8 +: 8] <= b_data_i[i*8 +: 8];
      end
    end
  end

  // registered read, old data on a same-cycle write
  always_ff @(posedge clk_125) begin
    a_q_o <= mem[a_addr_i];
  end

  // host and receiver must never hit one word together
  a_no_write_collision : assert property (
    @(posedge clk_125) disable iff (!core_rst_n)
    !(a_we_i && b_we_i && (a_addr_i == b_addr_i))
  ) else $error("slot_ram: both ports write word %0h", a_addr_i);

endmodule

/* verilog/gmii_rx_slot.sv */
`timescale 1ns/1ps

module gmii_rx_slot import eth_pkg::*; (
  input  logic       clk_125,
  input  logic       core_rst_n,
  // GMII receive
  input  logic       gmii_rx_dv_i,
  input  gmii_byte_t gmii_rxd_i,
  // slot state and time base from the host side
  input  logic       slot_empty_i,
  input  stamp_t     global_count_i,
  // slot memory port B
  output slot_addr_t ram_addr_o,
  output slot_word_t ram_data_o,
  output slot_be_t   ram_be_o,
  output logic       ram_we_o,
  // frame result
  output logic       frame_done_o,
  output stamp_t     rx_stamp_o,
  output frame_len_t rx_len_o
);

  rx_state_t state_q;
  logic      sfd_hit;
  logic      byte_in;
  logic      start_empty_q;

  // SFD seen from idle or after preamble bytes
  assign sfd_hit = gmii_rx_dv_i && (gmii_rxd_i == GMII_SFD) &&
                   ((state_q == PREAMBLE) || ((state_q == IDLE) && slot_empty_i));

  assign byte_in = (state_q == DATA) && gmii_rx_dv_i;

  assign frame_done_o = (state_q == DONE);

  // --------------------------------------------------------------------------
  // receive FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      state_q       <= IDLE;
      start_empty_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (gmii_rx_dv_i) begin
            start_empty_q <= slot_empty_i;
            if (!slot_empty_i) begin
              // slot still owned by the host
              state_q <= DROP;
            end else if (sfd_hit) begin
              state_q <= DATA;
            end else if (gmii_rxd_i == GMII_PREAMBLE) begin
              state_q <= PREAMBLE;
            end else begin
              state_q <= DROP;
            end
          end
        end
        PREAMBLE: begin
          if (!gmii_rx_dv_i) begin
            state_q <= IDLE;
          end else if (sfd_hit) begin
            state_q <= DATA;
          end else if (gmii_rxd_i != GMII_PREAMBLE) begin
            state_q <= DROP;
          end
        end
        DATA: begin
          if (!gmii_rx_dv_i) begin
            // empty frames leave the slot alone
            state_q <= (rx_len_o != '0) ? DONE : IDLE;
          end
        end
        DROP: begin
          if (!gmii_rx_dv_i) begin
            state_q <= IDLE;
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // timestamp, length and slot writes
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      rx_stamp_o <= '0;
      rx_len_o   <= '0;
      ram_we_o   <= 1'b0;
    end else begin
      ram_we_o <= 1'b0;
      if (sfd_hit) begin
        rx_stamp_o <= global_count_i;
        rx_len_o   <= '0;
      end else if (byte_in) begin
        // length doubles as byte index, saturating
        if (rx_len_o != '1) begin
          rx_len_o <= rx_len_o + 1'b1;
        end
        if (rx_len_o < SLOT_WORDS * 4) begin
          ram_we_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_125) begin
    if (byte_in) begin
      ram_addr_o <= rx_len_o[10:2];
      ram_data_o <= {4{gmii_rxd_i}};
      ram_be_o   <= slot_be_t'(1) << rx_len_o[1:0];
    end
  end

  // a completed frame must have begun while the slot was free
  a_done_only_when_empty : assert property (
    @(posedge clk_125) disable iff (!core_rst_n)
    frame_done_o |-> start_empty_q
  ) else $error("gmii_rx_slot: frame_done for a frame taken into a full slot");

endmodule

/* verilog/host_regs.sv */
`timescale 1ns/1ps

module host_regs import eth_pkg::*; (
  input  logic       clk_125,
  input  logic       core_rst_n,
  // host register bus
  input  logic       host_stb_i,
  input  logic       host_we_i,
  input  host_addr_t host_adr_i,
  input  host_data_t host_dat_i,
  input  host_sel_t  host_sel_i,
  output logic       host_ack_o,
  output host_data_t host_dat_o,
  // frame info from the receiver
  input  logic       frame_done_i,
  input  stamp_t     rx_stamp_i,
  input  frame_len_t rx_len_i,
  // slot memory port A
  output slot_addr_t ram_addr_o,
  output slot_word_t ram_data_o,
  output slot_be_t   ram_be_o,
  output logic       ram_we_o,
  input  slot_word_t ram_q_i,
  // status and time base
  output logic       slot_empty_o,
  output logic       rx_ready_o,
  output stamp_t     global_count_o
);

  logic [11:0]  word_idx;
  logic [1:0]   ctr_piece;
  logic [1:0]   stamp_piece;
  logic         in_global;
  logic         in_rx;
  logic         is_status;
  logic         is_counter;
  logic         is_stamp;
  logic         is_len;
  logic         is_slot;
  logic         slow_read;
  logic         start;
  logic [2:0]   rd_wait;
  slot_status_t status_q;
  stamp_t       count_q;
  stamp_t       cnt_next;
  slot_word_t   rd_word_q;
  host_data_t   rd_value;

  // --------------------------------------------------------------------------
  // address decode
  // --------------------------------------------------------------------------

  assign word_idx    = host_adr_i[12:1];
  assign ctr_piece   = word_idx[1:0] - 2'(GLB_COUNTER_WORD);
  assign stamp_piece = word_idx[1:0] - 2'(RX_STAMP_WORD);

  assign in_global = (host_adr_i[15:13] == REGION_GLOBAL);
  assign in_rx     = (host_adr_i[15:13] == REGION_RX);

  assign is_status  = in_global && (word_idx == GLB_STATUS_WORD);
  assign is_counter = in_global && ((word_idx - GLB_COUNTER_WORD) < 4);
  assign is_stamp   = in_rx && ((word_idx - RX_STAMP_WORD) < 4);
  assign is_len     = in_rx && (word_idx == RX_LEN_WORD);
  assign is_slot    = in_rx && (word_idx >= RX_DATA_WORD);

  // low half of a slot word waits on the memory
  assign slow_read = is_slot && !host_we_i && !host_adr_i[1];

  // new access when the strobe is up outside the ack cycle with no read pending
  assign start = host_stb_i && !host_ack_o && (rd_wait == '0);

  always_comb begin
    rd_value = '0;
    if (is_status) begin
      rd_value = host_data_t'(status_q);
    end else if (is_counter) begin
      rd_value = count_q[ctr_piece*16 +: 16];
    end else if (is_stamp) begin
      rd_value = rx_stamp_i[stamp_piece*16 +: 16];
    end else if (is_len) begin
      rd_value = host_data_t'(rx_len_i);
    end else if (is_slot) begin
      // high half comes from the last low-half read
      rd_value = rd_word_q[31:16];
    end
  end

  // --------------------------------------------------------------------------
  // global counter, status and handshake
  // --------------------------------------------------------------------------

  always_comb begin
    cnt_next = count_q + 64'd1;
    if (start && host_we_i && is_counter) begin
      if (host_sel_i[0]) begin
        cnt_next[ctr_piece*16 +: 8] = host_dat_i[7:0];
      end
      if (host_sel_i[1]) begin
        cnt_next[ctr_piece*16 + 8 +: 8] = host_dat_i[15:8];
      end
    end
  end

  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      count_q    <= '0;
      status_q   <= STATUS_RESET;
      host_ack_o <= 1'b0;
      ram_we_o   <= 1'b0;
      rd_wait    <= '0;
    end else begin
      count_q <= cnt_next;

      if (start && host_we_i && is_status && host_sel_i[0]) begin
        status_q <= host_dat_i[3:0];
      end
      // frame completion beats a host write
      if (frame_done_i) begin
        status_q[1:0] <= 2'b01;
      end

      ram_we_o <= start && host_we_i && is_slot;

      if (start && slow_read) begin
        rd_wait <= 3'(RAM_READ_WAIT);
      end else if (rd_wait != '0) begin
        rd_wait <= rd_wait - 1'b1;
      end

      host_ack_o <= (start && !slow_read) || (rd_wait == 3'd1);
    end
  end

  // --------------------------------------------------------------------------
  // read data and slot port A payload
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_125) begin
    if (start) begin
      host_dat_o <= rd_value;
    end else if (rd_wait == 3'd1) begin
      host_dat_o <= ram_q_i[15:0];
      rd_word_q  <= ram_q_i;
    end

    if (start && is_slot) begin
      ram_addr_o <= slot_addr_t'(host_adr_i[10:2] - slot_addr_t'(RX_DATA_WORD / 2));
      ram_data_o <= {host_dat_i, host_dat_i};
      ram_be_o   <= host_adr_i[1] ? {host_sel_i, 2'b00} : {2'b00, host_sel_i};
    end
  end

  assign slot_empty_o   = status_q[1];
  assign rx_ready_o     = status_q[0];
  assign global_count_o = count_q;

  a_ack_single_cycle : assert property (
    @(posedge clk_125) disable iff (!core_rst_n)
    host_ack_o |=> !host_ack_o
  ) else $error("host_regs: acknowledge held for two cycles");

endmodule

/* verilog/eth_top.sv */
`timescale 1ns/1ps

module eth_top import eth_pkg::*; (
  input  logic       clk_125,
  input  logic       core_rst_n,
  // GMII receive
  input  logic       gmii_rx_dv_i,
  input  gmii_byte_t gmii_rxd_i,
  // host register bus
  input  logic       host_stb_i,
  input  logic       host_we_i,
  input  host_addr_t host_adr_i,
  input  host_data_t host_dat_i,
  input  host_sel_t  host_sel_i,
  output logic       host_ack_o,
  output host_data_t host_dat_o,
  // frame-complete interrupt
  output logic       rx_ready_o
);

  slot_addr_t ram_a_addr;
  slot_word_t ram_a_data;
  slot_be_t   ram_a_be;
  logic       ram_a_we;
  slot_word_t ram_a_q;
  slot_addr_t ram_b_addr;
  slot_word_t ram_b_data;
  slot_be_t   ram_b_be;
  logic       ram_b_we;
  logic       frame_done;
  stamp_t     rx_stamp;
  frame_len_t rx_len;
  logic       slot_empty;
  stamp_t     global_count;

  slot_ram i_slot_ram (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .a_addr_i   (ram_a_addr),
    .a_data_i   (ram_a_data),
    .a_be_i     (ram_a_be),
    .a_we_i     (ram_a_we),
    .a_q_o      (ram_a_q),
    .b_addr_i   (ram_b_addr),
    .b_data_i   (ram_b_data),
    .b_be_i     (ram_b_be),
    .b_we_i     (ram_b_we)
  );

  gmii_rx_slot i_gmii_rx_slot (
    .clk_125        (clk_125),
    .core_rst_n     (core_rst_n),
    .gmii_rx_dv_i   (gmii_rx_dv_i),
    .gmii_rxd_i     (gmii_rxd_i),
    .slot_empty_i   (slot_empty),
    .global_count_i (global_count),
    .ram_addr_o     (ram_b_addr),
    .ram_data_o     (ram_b_data),
    .ram_be_o       (ram_b_be),
    .ram_we_o       (ram_b_we),
    .frame_done_o   (frame_done),
    .rx_stamp_o     (rx_stamp),
    .rx_len_o       (rx_len)
  );

  host_regs i_host_regs (
    .clk_125        (clk_125),
    .core_rst_n     (core_rst_n),
    .host_stb_i     (host_stb_i),
    .host_we_i      (host_we_i),
    .host_adr_i     (host_adr_i),
    .host_dat_i     (host_dat_i),
    .host_sel_i     (host_sel_i),
    .host_ack_o     (host_ack_o),
    .host_dat_o     (host_dat_o),
    .frame_done_i   (frame_done),
    .rx_stamp_i     (rx_stamp),
    .rx_len_i       (rx_len),
    .ram_addr_o     (ram_a_addr),
    .ram_data_o     (ram_a_data),
    .ram_be_o       (ram_a_be),
    .ram_we_o       (ram_a_we),
    .ram_q_i        (ram_a_q),
    .slot_empty_o   (slot_empty),
    .rx_ready_o     (rx_ready_o),
    .global_count_o (global_count)
  );

endmodule

/* sim/eth_checker.sv */
`timescale 1ns/1ps

module eth_checker import eth_pkg::*; (
  input  logic        clk_125,
  input  logic        core_rst_n,
  input  logic        gmii_rx_dv_i,
  input  gmii_byte_t  gmii_rxd_i,
  input  logic        host_stb_i,
  input  logic        host_we_i,
  input  host_addr_t  host_adr_i,
  input  host_data_t  host_dat_i,
  input  host_sel_t   host_sel_i,
  input  logic        host_ack_o,
  input  host_data_t  host_dat_o,
  input  logic        rx_ready_o,
  output logic [31:0] errors_o
);

  gmii_byte_t   mem_m [SLOT_WORDS * 4];
  stamp_t       cnt_m;
  stamp_t       cnt_next;
  stamp_t       stamp_m;
  int           len_m;
  slot_status_t status_m;
  slot_word_t   last_word_m;
  host_data_t   exp_rd;
  host_addr_t   adr_q;
  int           lat;
  int           exp_lat;
  logic         busy;
  logic         is_read;
  logic         in_frame;
  logic         take;
  logic         sfd_seen;
  logic         done_q;
  logic         done_now;

  initial begin
    errors_o = 0;
    for (int i = 0; i < SLOT_WORDS * 4; i++) begin
      mem_m[i] = '0;
    end
  end

  function automatic int slot_index(input host_addr_t adr);
    return int'(slot_addr_t'(adr[10:2] - 9'd4));
  endfunction

  function automatic slot_word_t slot_word(input int idx);
    return {mem_m[idx * 4 + 3], mem_m[idx * 4 + 2], mem_m[idx * 4 + 1], mem_m[idx * 4]};
  endfunction

  // expected read data from the register map
  function automatic host_data_t read_model(input host_addr_t adr);
    int         w;
    slot_word_t word;
    w = int'(adr[12:1]);
    if (adr[15:13] == REGION_GLOBAL) begin
      if (w == GLB_STATUS_WORD) return {12'h0, status_m};
      if (w >= 2 && w <= 5) return cnt_m[(w - 2) * 16 +: 16];
    end else if (adr[15:13] == REGION_RX) begin
      if (w <= 3) return stamp_m[w * 16 +: 16];
      if (w == RX_LEN_WORD) return host_data_t'(len_m);
      if (w >= RX_DATA_WORD) begin
        word = slot_word(slot_index(adr));
        return adr[1] ? last_word_m[31:16] : word[15:0];
      end
    end
    return '0;
  endfunction

  task automatic host_store();
    int w;
    int base;
    w = int'(host_adr_i[12:1]);
    if (host_adr_i[15:13] == REGION_GLOBAL) begin
      if (w == GLB_STATUS_WORD && host_sel_i[0]) begin
        status_m = host_dat_i[3:0];
      end else if (w >= 2 && w <= 5) begin
        if (host_sel_i[0]) cnt_next[(w - 2) * 16 +: 8] = host_dat_i[7:0];
        if (host_sel_i[1]) cnt_next[(w - 2) * 16 + 8 +: 8] = host_dat_i[15:8];
      end
    end else if (host_adr_i[15:13] == REGION_RX && w >= RX_DATA_WORD) begin
      base = slot_index(host_adr_i) * 4 + (host_adr_i[1] ? 2 : 0);
      if (host_sel_i[0]) mem_m[base] = host_dat_i[7:0];
      if (host_sel_i[1]) mem_m[base + 1] = host_dat_i[15:8];
    end
  endtask

  always @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      cnt_m    = '0;
      stamp_m  = '0;
      len_m    = 0;
      status_m = STATUS_RESET;
      busy     = 1'b0;
      in_frame = 1'b0;
      done_q   = 1'b0;
    end else begin
      if (rx_ready_o !== status_m[0]) begin
        $display("FAILED rx_ready_o got %h exp %h", rx_ready_o, status_m[0]);
        errors_o = errors_o + 1;
      end
      if (busy) begin
        lat = lat + 1;
      end
      if (host_ack_o && busy) begin
        busy = 1'b0;
        if (lat != exp_lat) begin
          $display("FAILED host_ack_o latency adr %h got %h exp %h", adr_q, lat, exp_lat);
          errors_o = errors_o + 1;
        end
        if (is_read && host_dat_o !== exp_rd) begin
          $display("FAILED host_dat_o adr %h got %h exp %h", adr_q, host_dat_o, exp_rd);
          errors_o = errors_o + 1;
        end
      end else if (host_ack_o) begin
        $display("acknowledge seen with no host access pending");
        errors_o = errors_o + 1;
      end
      cnt_next = cnt_m + 64'd1;
      done_now = done_q;
      done_q   = 1'b0;

      // ---------------------------------------------------------------------
      // receive model
      // ---------------------------------------------------------------------
      if (gmii_rx_dv_i) begin
        if (!in_frame) begin
          in_frame = 1'b1;
          take     = status_m[1];
          sfd_seen = 1'b0;
        end
        if (!sfd_seen && gmii_rxd_i == GMII_SFD) begin
          sfd_seen = 1'b1;
          if (take) begin
            stamp_m = cnt_m;
            len_m   = 0;
          end
        end else if (sfd_seen && take) begin
          if (len_m < SLOT_WORDS * 4) mem_m[len_m] = gmii_rxd_i;
          if (len_m < 4095) len_m++;
        end
      end else if (in_frame) begin
        in_frame = 1'b0;
        done_q   = take && sfd_seen && (len_m > 0);
      end

      if (host_stb_i && !host_ack_o && !busy) begin
        busy    = 1'b1;
        is_read = !host_we_i;
        adr_q   = host_adr_i;
        lat     = 0;
        exp_lat = 1;
        if (host_we_i) begin
          host_store();
        end else begin
          exp_rd = read_model(host_adr_i);
          if (host_adr_i[15:13] == REGION_RX && host_adr_i[12:1] >= RX_DATA_WORD &&
              !host_adr_i[1]) begin
            last_word_m = slot_word(slot_index(host_adr_i));
            exp_lat     = 1 + RAM_READ_WAIT;
          end
        end
      end
      // frame completion wins over a host write
      if (done_now) begin
        status_m[1:0] = 2'b01;
      end
      cnt_m = cnt_next;
    end
  end

endmodule

/* sim/tb_eth_top.sv */
`timescale 1ns/1ps

module tb_eth_top import eth_pkg::*; ();

  localparam int NUM_TESTS = 6;

  logic        clk_125;
  logic        core_rst_n;
  logic        gmii_rx_dv_i;
  gmii_byte_t  gmii_rxd_i;
  logic        host_stb_i;
  logic        host_we_i;
  host_addr_t  host_adr_i;
  host_data_t  host_dat_i;
  host_sel_t   host_sel_i;
  logic        host_ack_o;
  host_data_t  host_dat_o;
  logic        rx_ready_o;
  logic [31:0] chk_errors;

  int         seed = 32'hbaa2bb28;
  int         tb_errors = 0;
  int         last_total = 0;
  int         tests_done = 0;
  host_data_t rd;
  host_data_t val_a;
  host_data_t val_b;
  host_data_t top_piece;
  host_data_t first_len;
  host_data_t first_stamp;
  int         nbytes;

  eth_top i_eth_top (
    .clk_125      (clk_125),
    .core_rst_n   (core_rst_n),
    .gmii_rx_dv_i (gmii_rx_dv_i),
    .gmii_rxd_i   (gmii_rxd_i),
    .host_stb_i   (host_stb_i),
    .host_we_i    (host_we_i),
    .host_adr_i   (host_adr_i),
    .host_dat_i   (host_dat_i),
    .host_sel_i   (host_sel_i),
    .host_ack_o   (host_ack_o),
    .host_dat_o   (host_dat_o),
    .rx_ready_o   (rx_ready_o)
  );

  eth_checker i_eth_checker (
    .clk_125      (clk_125),
    .core_rst_n   (core_rst_n),
    .gmii_rx_dv_i (gmii_rx_dv_i),
    .gmii_rxd_i   (gmii_rxd_i),
    .host_stb_i   (host_stb_i),
    .host_we_i    (host_we_i),
    .host_adr_i   (host_adr_i),
    .host_dat_i   (host_dat_i),
    .host_sel_i   (host_sel_i),
    .host_ack_o   (host_ack_o),
    .host_dat_o   (host_dat_o),
    .rx_ready_o   (rx_ready_o),
    .errors_o     (chk_errors)
  );

  initial begin
    clk_125 = 1'b0;
    forever #2 clk_125 = ~clk_125;
  end

  // ---------------------------------------------------------------------------
  // bus and frame helpers
  // ---------------------------------------------------------------------------

  task automatic tick();
    @(posedge clk_125);
    #1;
  endtask

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // ack seen at the edge, so data is the one held in the ack cycle
  task automatic host_access(input logic we, input host_addr_t adr, input host_data_t dat,
                             input host_sel_t sel, output host_data_t q);
    host_stb_i = 1'b1;
    host_we_i  = we;
    host_adr_i = adr;
    host_dat_i = dat;
    host_sel_i = sel;
    do begin
      @(posedge clk_125);
    end while (!host_ack_o);
    q = host_dat_o;
    #1;
    host_stb_i = 1'b0;
    host_we_i  = 1'b0;
  endtask

  task automatic host_write(input host_addr_t adr, input host_data_t dat, input host_sel_t sel);
    host_data_t unused;
    host_access(1'b1, adr, dat, sel, unused);
  endtask

  task automatic host_read(input host_addr_t adr, output host_data_t q);
    host_access(1'b0, adr, 16'h0, 2'b11, q);
  endtask

  task automatic send_frame(input int n);
    int pre;
    pre = rand_range(1, 7);
    gmii_rx_dv_i = 1'b1;
    for (int i = 0; i < pre; i++) begin
      gmii_rxd_i = GMII_PREAMBLE;
      tick();
    end
    gmii_rxd_i = GMII_SFD;
    tick();
    for (int i = 0; i < n; i++) begin
      gmii_rxd_i = gmii_byte_t'($random(seed));
      tick();
    end
    gmii_rx_dv_i = 1'b0;
    gmii_rxd_i   = '0;
    repeat (4) tick();
  endtask

  task automatic wait_ready();
    while (!rx_ready_o) begin
      tick();
    end
  endtask

  // low half first so the high half reuses its latched word
  task automatic read_slot_words(input int n);
    host_data_t q;
    for (int k = 0; k < (n + 3) / 4; k++) begin
      host_read(host_addr_t'(16'h8010 + 4 * k), q);
      host_read(host_addr_t'(16'h8012 + 4 * k), q);
    end
  endtask

  task automatic check_equal(input string name, input host_data_t got, input host_data_t exp);
    if (got !== exp) begin
      $display("FAILED %s got %h exp %h", name, got, exp);
      tb_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    int total;
    repeat (2) tick();
    total = tb_errors + int'(chk_errors);
    tests_done++;
    if (total == last_total) begin
      $display("test %0d %s: ok", tests_done, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_done, name, total - last_total);
    end
    last_total = total;
  endtask

  // ---------------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------------

  initial begin
    core_rst_n   = 1'b0;
    gmii_rx_dv_i = 1'b0;
    gmii_rxd_i   = '0;
    host_stb_i   = 1'b0;
    host_we_i    = 1'b0;
    host_adr_i   = '0;
    host_dat_i   = '0;
    host_sel_i   = '0;
    repeat (2) @(posedge clk_125);
    #1;
    core_rst_n = 1'b1;
    tick();

    host_read(16'h0000, rd);
    check_equal("status", rd, 16'h0002);
    if (rx_ready_o !== 1'b0) begin
      $display("FAILED rx_ready_o got %h exp %h", rx_ready_o, 1'b0);
      tb_errors++;
    end
    host_read(16'h0004, val_a);
    host_read(16'h0004, val_b);
    if (val_b - val_a == 16'h0 || val_b - val_a > 16'd100) begin
      $display("counter did not count up between reads (%h then %h)", val_a, val_b);
      tb_errors++;
    end
    finish_test("reset values");

    for (int p = 0; p < 4; p++) begin
      top_piece = host_data_t'($random(seed));
      host_write(host_addr_t'(16'h0004 + 2 * p), top_piece, 2'b11);
    end
    host_read(16'h000a, rd);
    check_equal("counter top piece", rd, top_piece);
    finish_test("counter write");

    host_read(16'h0004, val_a);
    nbytes = rand_range(20, 200);
    send_frame(nbytes);
    wait_ready();
    host_read(16'h0004, val_b);
    host_read(16'h0000, rd);
    check_equal("status", rd, 16'h0001);
    host_read(16'h800c, first_len);
    check_equal("rx length", first_len, host_data_t'(nbytes));
    read_slot_words(nbytes);
    finish_test("frame receive");

    host_read(16'h8000, first_stamp);
    if (first_stamp - val_a > val_b - val_a) begin
      $display("timestamp %h outside counter window %h to %h", first_stamp, val_a, val_b);
      tb_errors++;
    end
    finish_test("frame timestamp");

    send_frame(rand_range(20, 200));
    host_read(16'h800c, rd);
    check_equal("rx length", rd, host_data_t'(nbytes));
    host_read(16'h8000, rd);
    check_equal("rx stamp", rd, first_stamp);
    read_slot_words(nbytes);
    host_write(16'h0000, 16'h0002, 2'b01);
    nbytes = rand_range(20, 200);
    send_frame(nbytes);
    wait_ready();
    host_read(16'h800c, rd);
    check_equal("rx length", rd, host_data_t'(nbytes));
    read_slot_words(nbytes);
    finish_test("full slot drop");

    for (int r = 0; r < 8; r++) begin
      int k;
      k = rand_range(0, 127);
      host_write(host_addr_t'(16'h8010 + 4 * k), host_data_t'($random(seed)), 2'b11);
      host_write(host_addr_t'(16'h8012 + 4 * k), host_data_t'($random(seed)), 2'b11);
      for (int j = 0; j < 4; j++) begin
        host_write(host_addr_t'(16'h8010 + 4 * k + 2 * (j % 2)),
                   host_data_t'($random(seed)), host_sel_t'($random(seed)));
      end
      host_read(host_addr_t'(16'h8010 + 4 * k), rd);
      host_read(host_addr_t'(16'h8012 + 4 * k), rd);
    end
    host_read(16'h8008, rd);
    host_read(16'h800a, rd);
    host_read(16'h800e, rd);
    host_read(host_addr_t'(16'h2000 + 2 * rand_range(0, 4000)), rd);
    host_read(16'h4006, rd);
    finish_test("slot access");

    $display("summary: %0d tests, %0d errors", tests_done, last_total);
    if (last_total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (NUM_TESTS * 2000) @(posedge clk_125);
    $display("watchdog: the run did not finish within %0d cycles", NUM_TESTS * 2000);
    $display("Test failures found");
    $finish;
  end

endmodule

/* project.f */
verilog/eth_pkg.sv
verilog/slot_ram.sv
verilog/gmii_rx_slot.sv
verilog/host_regs.sv
verilog/eth_top.sv
sim/eth_checker.sv
sim/tb_eth_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then check the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_eth_top \
  -f project.f \
  -o tb_eth_top_sim

./obj_dir/tb_eth_top_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
  exit 0
else
  exit 1
fi
